// ==== all.f ====
+incdir+hw
hw/rec_cmd_pkg.sv
hw/rec_reg_pkg.sv
hw/rec_cmd_fsm.sv
hw/rec_csr_bank.sv
hw/rec_fifo_tracker.sv
hw/rec_resp_mux.sv
hw/rec_executor.sv
sim/tb_rec_executor.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_rec_executor
FILELIST   = all.f
FLAGS      = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_rec_executor.sv ====
// Recovery executor testbench
`timescale 1ns/1ps
`default_nettype none

`include "rec_defines.svh"

module tb_rec_executor
  import rec_cmd_pkg::*;
();

  localparam int TIMEOUT = 2000;

  typedef logic [7:0] byte_q_t[$];

  logic                   clk_i;
  logic                   rst_ni;
  logic                   cmd_valid_i;
  rec_cmd_t               cmd_i;
  logic                   cmd_done_o;
  logic                   res_valid_o;
  logic                   res_ready_i;
  logic [`REC_LEN_W-1:0]  res_len_o;
  logic                   res_dvalid_o;
  logic                   res_dready_i;
  logic [7:0]             res_data_o;
  logic                   res_dlast_o;
  logic                   tti_rx_rreq_o;
  logic                   tti_rx_rack_i;
  logic [`REC_WORD_W-1:0] tti_rx_rdata_i;
  logic                   rx_queue_clr_o;
  logic                   indirect_rx_wvalid_o;
  logic [`REC_WORD_W-1:0] indirect_rx_wdata_o;
  logic                   indirect_rx_rack_i;
  logic                   indirect_rx_full_i;
  logic                   indirect_rx_empty_i;
  logic                   indirect_rx_clr_o;
  logic                   recovery_mode_enabled_i;
  logic                   host_abort_i;
  logic                   payload_available_o;
  logic                   image_activated_o;

  // Observed per command
  int                    done_cnt;
  int                    clr_cnt;
  int                    valid_cnt;
  int                    rreq_cnt;
  int                    fclr_cnt;
  logic [`REC_LEN_W-1:0] len_seen;
  logic [7:0]            rx_bytes[$];
  logic                  rx_last[$];
  logic [31:0]           pushed[$];
  logic [31:0]           tti_words[$];
  int                    errors;
  int                    checks;

  // Reference model
  logic [31:0] m_dev_reset;
  logic [31:0] m_rec_ctrl;
  logic [31:0] m_fifo_ctrl;
  logic [31:0] m_image_size;
  int          m_wr;
  int          m_rd;
  logic [7:0]  m_prot;
  logic        m_full;
  logic        m_empty;
  logic        m_pa;

  rec_executor DUT (.*);

  always #2 clk_i = ~clk_i;

  // TTI queue answers each request after a random delay
  initial begin
    forever begin
      @(negedge clk_i);
      tti_rx_rack_i = 1'b0;
      if (rst_ni && tti_rx_rreq_o) begin
        repeat ($urandom_range(0, 3)) @(negedge clk_i);
        tti_rx_rack_i = 1'b1;
        if (tti_words.size() != 0) begin
          tti_rx_rdata_i = tti_words.pop_front();
        end else begin
          tti_rx_rdata_i = $urandom();
        end
      end
    end
  end

  // Response back-pressure
  initial begin
    forever begin
      @(negedge clk_i);
      res_ready_i  = ($urandom_range(0, 2) == 0);
      res_dready_i = ($urandom_range(0, 3) != 0);
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (cmd_done_o) done_cnt++;
      if (rx_queue_clr_o) clr_cnt++;
      if (tti_rx_rreq_o) rreq_cnt++;
      if (indirect_rx_clr_o) fclr_cnt++;
      if (indirect_rx_wvalid_o) pushed.push_back(indirect_rx_wdata_o);
      if (res_valid_o) begin
        valid_cnt++;
        len_seen = res_len_o;
      end
      if (res_dvalid_o && res_dready_i) begin
        rx_bytes.push_back(res_data_o);
        rx_last.push_back(res_dlast_o);
      end
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("Fail %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      errors++;
    end
  endtask

  function automatic byte_q_t word_bytes(input logic [31:0] w, input int n);
    byte_q_t q;
    for (int b = 0; b < n; b++) begin
      q.push_back(w[8*b +: 8]);
    end
    return q;
  endfunction

  function automatic byte_q_t fifo_status_bytes();
    logic [31:0] words[5];
    byte_q_t     q;
    words[0] = {30'd0, m_full, m_empty};
    words[1] = 32'(m_wr);
    words[2] = 32'(m_rd);
    words[3] = 32'(`REC_FIFO_DEPTH);
    words[4] = 32'd0;
    foreach (words[i]) begin
      for (int b = 0; b < 4; b++) begin
        q.push_back(words[i][8*b +: 8]);
      end
    end
    return q;
  endfunction

  // Control word, then the upper half of the image size
  function automatic byte_q_t fifo_ctrl_bytes();
    byte_q_t q;
    q = word_bytes(m_fifo_ctrl, 4);
    q.push_back(m_image_size[23:16]);
    q.push_back(m_image_size[31:24]);
    return q;
  endfunction

  // Issue one command and wait for its done pulse
  task automatic run_cmd(input logic [7:0] code, input logic is_rd, input logic [15:0] len,
                         input logic err);
    int cycles;
    cycles    = 0;
    done_cnt  = 0;
    clr_cnt   = 0;
    valid_cnt = 0;
    rreq_cnt  = 0;
    fclr_cnt  = 0;
    rx_bytes.delete();
    rx_last.delete();
    pushed.delete();
    @(negedge clk_i);
    cmd_i       = '{code: command_e'(code), is_rd: is_rd, len: len, error: err};
    cmd_valid_i = 1'b1;
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    while (!cmd_done_o && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    checks++;
    assert (cmd_done_o) else begin
      $display("Command 0x%0h did not finish within %0d cycles", code, TIMEOUT);
      errors++;
    end
    // Let the monitor see the done pulse
    @(negedge clk_i);
    m_prot = err ? 8'h04 : 8'h00;
  endtask

  task automatic read_and_check(input string name, input logic [7:0] code, input byte_q_t exp);
    run_cmd(code, 1'b1, 16'(exp.size()), 1'b0);
    check_val({name, " res_valid pulses"}, 1, valid_cnt);
    check_val({name, " res_len"}, exp.size(), len_seen);
    check_val({name, " byte count"}, exp.size(), rx_bytes.size());
    foreach (exp[i]) begin
      if (i < rx_bytes.size()) begin
        check_val($sformatf("%s byte %0d", name, i), exp[i], rx_bytes[i]);
        check_val($sformatf("%s dlast %0d", name, i), (i == exp.size() - 1), rx_last[i]);
      end
    end
  endtask

  task automatic write_word(input logic [7:0] code, input logic [31:0] w, input int len);
    tti_words.push_back(w);
    run_cmd(code, 1'b0, 16'(len), 1'b0);
    check_val("register write requests", 1, rreq_cnt);
  endtask

  task automatic fifo_data_write(input int len);
    logic [31:0] words[$];
    int          n;
    n = (len + 3) / 4;
    for (int i = 0; i < n; i++) begin
      words.push_back($urandom());
      tti_words.push_back(words[i]);
    end
    run_cmd(CMD_INDIRECT_FIFO_DATA, 1'b0, 16'(len), 1'b0);
    check_val("fifo write pushes", n, pushed.size());
    foreach (words[i]) begin
      if (i < pushed.size()) begin
        check_val($sformatf("fifo write word %0d", i), words[i], pushed[i]);
      end
    end
    m_wr = (m_wr + n) % `REC_FIFO_DEPTH;
  endtask

  task automatic pulse_fifo_reads(input int k);
    repeat (k) begin
      @(negedge clk_i);
      indirect_rx_rack_i = 1'b1;
      @(negedge clk_i);
      indirect_rx_rack_i = 1'b0;
      m_rd = (m_rd + 1) % `REC_FIFO_DEPTH;
    end
  endtask

  // Random full and empty levels, one cycle each
  task automatic toggle_levels(input int cycles, input logic act);
    repeat (cycles) begin
      m_full              = 1'($urandom_range(0, 1));
      m_empty             = 1'($urandom_range(0, 1));
      indirect_rx_full_i  = m_full;
      indirect_rx_empty_i = m_empty;
      if (!m_pa && (m_full || (act && !m_empty))) begin
        m_pa = 1'b1;
      end else if (m_pa && m_empty) begin
        m_pa = 1'b0;
      end
      @(negedge clk_i);
      check_val("payload_available", m_pa, payload_available_o);
    end
    m_full              = 1'b0;
    m_empty             = 1'b1;
    indirect_rx_full_i  = 1'b0;
    indirect_rx_empty_i = 1'b1;
    m_pa                = 1'b0;
    @(negedge clk_i);
    check_val("payload_available drained", m_pa, payload_available_o);
  endtask

  initial begin
    logic [31:0] w0;
    logic [31:0] w1;
    logic [7:0]  code;
    logic        err;
    int          kind;

    void'($urandom(31974));
    clk_i                   = 1'b0;
    rst_ni                  = 1'b0;
    cmd_valid_i             = 1'b0;
    cmd_i                   = '0;
    res_ready_i             = 1'b0;
    res_dready_i            = 1'b0;
    tti_rx_rack_i           = 1'b0;
    tti_rx_rdata_i          = '0;
    indirect_rx_rack_i      = 1'b0;
    indirect_rx_full_i      = 1'b0;
    indirect_rx_empty_i     = 1'b1;
    recovery_mode_enabled_i = 1'b1;
    host_abort_i            = 1'b0;
    errors                  = 0;
    checks                  = 0;
    m_wr                    = 0;
    m_rd                    = 0;
    m_prot                  = 8'h00;
    m_full                  = 1'b0;
    m_empty                 = 1'b1;
    m_pa                    = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // Control register write and readback
    repeat (6) begin
      m_dev_reset = $urandom();
      write_word(CMD_DEVICE_RESET, m_dev_reset, `REC_LEN_DEVICE_RESET);
      read_and_check("device_reset", CMD_DEVICE_RESET,
                     word_bytes(m_dev_reset, `REC_LEN_DEVICE_RESET));
      m_rec_ctrl = $urandom();
      write_word(CMD_RECOVERY_CTRL, m_rec_ctrl, `REC_LEN_RECOVERY_CTRL);
      read_and_check("recovery_ctrl", CMD_RECOVERY_CTRL,
                     word_bytes(m_rec_ctrl, `REC_LEN_RECOVERY_CTRL));
    end

    // Enough FIFO words to wrap both indices
    repeat (16) begin
      fifo_data_write($urandom_range(1, 64));
      pulse_fifo_reads($urandom_range(0, 7));
      read_and_check("fifo_status", CMD_INDIRECT_FIFO_STATUS, fifo_status_bytes());
    end

    // Rejected commands
    for (int i = 0; i < 12; i++) begin
      kind = i % 4;
      err  = 1'b0;
      case (kind)
        0:       code = 8'($urandom_range(0, `REC_CMD_FIRST - 1));
        1:       code = 8'($urandom_range(`REC_CMD_LAST + 1, 255));
        2:       code = 8'($urandom_range(`REC_CMD_MODE_LAST + 1, `REC_CMD_LAST));
        default: begin
          code = 8'($urandom_range(`REC_CMD_FIRST, `REC_CMD_LAST));
          err  = 1'b1;
        end
      endcase
      recovery_mode_enabled_i = (kind != 2);
      run_cmd(code, 1'($urandom_range(0, 1)), 16'($urandom_range(0, 16)), err);
      recovery_mode_enabled_i = 1'b1;
      check_val("reject res_valid pulses", 0, valid_cnt);
      check_val("reject data bytes", 0, rx_bytes.size());
      check_val("reject tti requests", 0, rreq_cnt);
      check_val("reject rx_queue_clr pulses", 1, clr_cnt);
      check_val("reject done pulses", 1, done_cnt);
      read_and_check("device_status after reject", CMD_DEVICE_STATUS,
                     word_bytes({16'd0, m_prot, 8'd0}, `REC_LEN_DEVICE_STATUS));
      read_and_check("device_status after read", CMD_DEVICE_STATUS,
                     word_bytes({16'd0, m_prot, 8'd0}, `REC_LEN_DEVICE_STATUS));
    end

    // FIFO reset through the control register
    repeat (3) begin
      fifo_data_write($urandom_range(4, 40));
      pulse_fifo_reads($urandom_range(1, 4));
      w0 = {16'($urandom()), 8'h01, 8'($urandom())};
      w1 = $urandom();
      tti_words.push_back(w0);
      tti_words.push_back(w1);
      run_cmd(CMD_INDIRECT_FIFO_CTRL, 1'b0, 16'd8, 1'b0);
      check_val("fifo clear pulses", 1, fclr_cnt);
      check_val("fifo ctrl pushes", 0, pushed.size());
      m_fifo_ctrl  = {w0[31:16], 8'h00, w0[7:0]};
      m_image_size = {w1[15:0], w0[31:16]};
      m_wr         = 0;
      m_rd         = 0;
      read_and_check("fifo_ctrl", CMD_INDIRECT_FIFO_CTRL, fifo_ctrl_bytes());
      read_and_check("fifo_status after clear", CMD_INDIRECT_FIFO_STATUS, fifo_status_bytes());
    end

    // Image activation and payload availability
    m_rec_ctrl = {8'($urandom()), `REC_IMAGE_ACTIVATE, 16'($urandom())};
    write_word(CMD_RECOVERY_CTRL, m_rec_ctrl, `REC_LEN_RECOVERY_CTRL);
    check_val("image_activated set", 1, image_activated_o);
    toggle_levels(40, 1'b1);
    m_rec_ctrl = {8'($urandom()), 8'h00, 16'($urandom())};
    write_word(CMD_RECOVERY_CTRL, m_rec_ctrl, `REC_LEN_RECOVERY_CTRL);
    check_val("image_activated clear", 0, image_activated_o);
    toggle_levels(40, 1'b0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/rec_executor.sv ====
// Recovery command executor
`timescale 1ns/1ps
`default_nettype none

`include "rec_defines.svh"

module rec_executor
  import rec_cmd_pkg::*;
  import rec_reg_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Command
  input  logic                   cmd_valid_i,
  input  rec_cmd_t               cmd_i,
  output logic                   cmd_done_o,
  // Response
  output logic                   res_valid_o,
  input  logic                   res_ready_i,
  output logic [`REC_LEN_W-1:0]  res_len_o,
  output logic                   res_dvalid_o,
  input  logic                   res_dready_i,
  output logic [7:0]             res_data_o,
  output logic                   res_dlast_o,
  // TTI receive queue
  output logic                   tti_rx_rreq_o,
  input  logic                   tti_rx_rack_i,
  input  logic [`REC_WORD_W-1:0] tti_rx_rdata_i,
  output logic                   rx_queue_clr_o,
  // Indirect FIFO
  output logic                   indirect_rx_wvalid_o,
  output logic [`REC_WORD_W-1:0] indirect_rx_wdata_o,
  input  logic                   indirect_rx_rack_i,
  input  logic                   indirect_rx_full_i,
  input  logic                   indirect_rx_empty_i,
  output logic                   indirect_rx_clr_o,
  // Recovery status
  input  logic                   recovery_mode_enabled_i,
  input  logic                   host_abort_i,
  output logic                   payload_available_o,
  output logic                   image_activated_o
);

  reg_idx_e                 reg_idx;
  logic                     reg_we;
  logic                     fifo_push;
  logic [1:0]               byte_sel;
  done_err_t                done_err;
  prot_err_e                device_status;
  device_reset_t            device_reset;
  recovery_ctrl_t           recovery_ctrl;
  fifo_ctrl_t               fifo_ctrl;
  logic [`REC_WORD_W-1:0]   image_size;
  logic                     fifo_clr;
  fifo_status_t             fifo_status;

  rec_cmd_fsm u_cmd_fsm (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .cmd_valid_i             (cmd_valid_i),
    .cmd_i                   (cmd_i),
    .recovery_mode_enabled_i (recovery_mode_enabled_i),
    .host_abort_i            (host_abort_i),
    .tti_rx_rack_i           (tti_rx_rack_i),
    .res_ready_i             (res_ready_i),
    .res_dready_i            (res_dready_i),
    .tti_rx_rreq_o           (tti_rx_rreq_o),
    .reg_idx_o               (reg_idx),
    .reg_we_o                (reg_we),
    .fifo_push_o             (fifo_push),
    .byte_sel_o              (byte_sel),
    .res_valid_o             (res_valid_o),
    .res_len_o               (res_len_o),
    .res_dvalid_o            (res_dvalid_o),
    .res_dlast_o             (res_dlast_o),
    .cmd_done_o              (cmd_done_o),
    .done_err_o              (done_err),
    .rx_queue_clr_o          (rx_queue_clr_o)
  );

  rec_csr_bank u_csr_bank (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .reg_idx_i         (reg_idx),
    .reg_we_i          (reg_we),
    .tti_rx_rdata_i    (tti_rx_rdata_i),
    .done_err_i        (done_err),
    .device_status_o   (device_status),
    .device_reset_o    (device_reset),
    .recovery_ctrl_o   (recovery_ctrl),
    .fifo_ctrl_o       (fifo_ctrl),
    .image_size_o      (image_size),
    .fifo_clr_o        (fifo_clr),
    .image_activated_o (image_activated_o)
  );

  rec_fifo_tracker u_fifo_tracker (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fifo_push_i         (fifo_push),
    .indirect_rx_rack_i  (indirect_rx_rack_i),
    .fifo_clr_i          (fifo_clr),
    .indirect_rx_full_i  (indirect_rx_full_i),
    .indirect_rx_empty_i (indirect_rx_empty_i),
    .image_activated_i   (image_activated_o),
    .fifo_status_o       (fifo_status),
    .payload_available_o (payload_available_o)
  );

  rec_resp_mux u_resp_mux (
    .reg_idx_i       (reg_idx),
    .byte_sel_i      (byte_sel),
    .device_status_i (device_status),
    .device_reset_i  (device_reset),
    .recovery_ctrl_i (recovery_ctrl),
    .fifo_ctrl_i     (fifo_ctrl),
    .image_size_i    (image_size),
    .fifo_status_i   (fifo_status),
    .res_data_o      (res_data_o)
  );

  // FIFO-data payload goes straight through to the indirect FIFO
  assign indirect_rx_wvalid_o = fifo_push;
  assign indirect_rx_wdata_o  = tti_rx_rdata_i;
  assign indirect_rx_clr_o    = fifo_clr;

endmodule

`default_nettype wire

// ==== hw/rec_resp_mux.sv ====
// Response byte selection
`timescale 1ns/1ps
`default_nettype none

`include "rec_defines.svh"

module rec_resp_mux
  import rec_cmd_pkg::*;
  import rec_reg_pkg::*;
(
  input  reg_idx_e               reg_idx_i,
  input  logic [1:0]             byte_sel_i,
  input  prot_err_e              device_status_i,
  input  device_reset_t          device_reset_i,
  input  recovery_ctrl_t         recovery_ctrl_i,
  input  fifo_ctrl_t             fifo_ctrl_i,
  input  logic [`REC_WORD_W-1:0] image_size_i,
  input  fifo_status_t           fifo_status_i,
  output logic [7:0]             res_data_o
);

  logic [3:0][7:0] word;

  always_comb begin
    word = '0;
    case (reg_idx_i)
      // Device status and reason code stay zero
      REG_DEVICE_STATUS: word[1] = device_status_i;
      REG_DEVICE_RESET:  word = device_reset_i;
      REG_RECOVERY_CTRL: word = recovery_ctrl_i;
      REG_FIFO_CTRL_0:   word = fifo_ctrl_i;
      // Low half of the image size already went out in the first word
      REG_FIFO_CTRL_1:   word = 32'(image_size_i[31:16]);
      REG_FIFO_STATUS_0: word[0] = {6'd0, fifo_status_i.full, fifo_status_i.empty};
      REG_FIFO_STATUS_1: word = 32'(fifo_status_i.write_index);
      REG_FIFO_STATUS_2: word = 32'(fifo_status_i.read_index);
      REG_FIFO_STATUS_3: word = 32'(`REC_FIFO_DEPTH);
      default:           word = '0;
    endcase
  end

  assign res_data_o = word[byte_sel_i];

endmodule

`default_nettype wire

// ==== hw/rec_fifo_tracker.sv ====
// Indirect FIFO index tracking
`timescale 1ns/1ps
`default_nettype none

`include "rec_defines.svh"

module rec_fifo_tracker
  import rec_reg_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         fifo_push_i,
  input  logic         indirect_rx_rack_i,
  input  logic         fifo_clr_i,
  input  logic         indirect_rx_full_i,
  input  logic         indirect_rx_empty_i,
  input  logic         image_activated_i,
  output fifo_status_t fifo_status_o,
  output logic         payload_available_o
);

  typedef logic [$clog2(`REC_FIFO_DEPTH)-1:0] idx_t;

  idx_t wr_idx_q;
  idx_t rd_idx_q;
  logic full_q;
  logic empty_q;

  function automatic idx_t wrap_inc(idx_t idx);
    return (idx == idx_t'(`REC_FIFO_DEPTH - 1)) ? '0 : idx + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_idx_q            <= '0;
      rd_idx_q            <= '0;
      full_q              <= 1'b0;
      empty_q             <= 1'b1;
      payload_available_o <= 1'b0;
    end else begin
      full_q  <= indirect_rx_full_i;
      empty_q <= indirect_rx_empty_i;
      if (fifo_clr_i) begin
        wr_idx_q <= '0;
        rd_idx_q <= '0;
      end else begin
        if (fifo_push_i) begin
          wr_idx_q <= wrap_inc(wr_idx_q);
        end
        if (indirect_rx_rack_i) begin
          rd_idx_q <= wrap_inc(rd_idx_q);
        end
      end
      // Set on a full FIFO or on activation with data left, drop when drained
      if (!payload_available_o
          && (indirect_rx_full_i || (image_activated_i && !indirect_rx_empty_i))) begin
        payload_available_o <= 1'b1;
      end else if (payload_available_o && indirect_rx_empty_i) begin
        payload_available_o <= 1'b0;
      end
    end
  end

  assign fifo_status_o = '{write_index: wr_idx_q, read_index: rd_idx_q,
                           full: full_q, empty: empty_q};

endmodule

`default_nettype wire

// ==== hw/rec_csr_bank.sv ====
// Writable recovery registers
`timescale 1ns/1ps
`default_nettype none

`include "rec_defines.svh"

module rec_csr_bank
  import rec_cmd_pkg::*;
  import rec_reg_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  reg_idx_e               reg_idx_i,
  input  logic                   reg_we_i,
  input  logic [`REC_WORD_W-1:0] tti_rx_rdata_i,
  input  done_err_t              done_err_i,
  output prot_err_e              device_status_o,
  output device_reset_t          device_reset_o,
  output recovery_ctrl_t         recovery_ctrl_o,
  output fifo_ctrl_t             fifo_ctrl_o,
  output logic [`REC_WORD_W-1:0] image_size_o,
  output logic                   fifo_clr_o,
  output logic                   image_activated_o
);

  payload_word_u wdata;
  payload_word_u prev_q;

  assign wdata = tti_rx_rdata_i;

  // Last written word, holds the low half of the image size
  always_ff @(posedge clk_i) begin
    if (reg_we_i) begin
      prev_q <= wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      device_status_o <= PROT_OK;
      device_reset_o  <= '0;
      recovery_ctrl_o <= '0;
      fifo_ctrl_o     <= '0;
      image_size_o    <= '0;
    end else begin
      if (done_err_i.done) begin
        device_status_o <= done_err_i.err ? PROT_CRC : PROT_OK;
      end
      // Reset byte is a one-shot, a new write below still wins
      if (fifo_ctrl_o.reset != 8'd0) begin
        fifo_ctrl_o.reset <= 8'd0;
      end
      if (reg_we_i) begin
        case (reg_idx_i)
          REG_DEVICE_RESET:  device_reset_o  <= wdata.dev_reset;
          REG_RECOVERY_CTRL: recovery_ctrl_o <= wdata.rec_ctrl;
          REG_FIFO_CTRL_0:   fifo_ctrl_o     <= wdata.fifo_ctrl;
          REG_FIFO_CTRL_1: begin
            image_size_o <= {wdata.bytes[1], wdata.bytes[0],
                             prev_q.bytes[3], prev_q.bytes[2]};
          end
          default: ;
        endcase
      end
    end
  end

  assign fifo_clr_o        = (fifo_ctrl_o.reset == 8'd1);
  assign image_activated_o = (recovery_ctrl_o.activate_rec_img == `REC_IMAGE_ACTIVATE);

endmodule

`default_nettype wire

// ==== hw/rec_cmd_fsm.sv ====
// Recovery command sequencer
`timescale 1ns/1ps
`default_nettype none

`include "rec_defines.svh"

module rec_cmd_fsm
  import rec_cmd_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cmd_valid_i,
  input  rec_cmd_t              cmd_i,
  input  logic                  recovery_mode_enabled_i,
  input  logic                  host_abort_i,
  input  logic                  tti_rx_rack_i,
  input  logic                  res_ready_i,
  input  logic                  res_dready_i,
  output logic                  tti_rx_rreq_o,
  output reg_idx_e              reg_idx_o,
  output logic                  reg_we_o,
  output logic                  fifo_push_o,
  output logic [1:0]            byte_sel_o,
  output logic                  res_valid_o,
  output logic [`REC_LEN_W-1:0] res_len_o,
  output logic                  res_dvalid_o,
  output logic                  res_dlast_o,
  output logic                  cmd_done_o,
  output done_err_t             done_err_o,
  output logic                  rx_queue_clr_o
);

  state_e                state_q, state_d;
  logic [`REC_LEN_W-1:0] dcnt_q;
  logic [`REC_LEN_W-1:0] res_len_q;
  logic [`REC_LEN_W-1:0] word_cnt;
  logic [`REC_LEN_W-1:0] start_len;
  logic [1:0]            bcnt_q;
  reg_idx_e              reg_idx_q;
  reg_idx_e              start_idx;
  logic                  err_q;
  logic                  cmd_bad;
  logic                  byte_hs;

  // Step to the next word, running off the end into INVALID
  function automatic reg_idx_e step_idx(reg_idx_e idx);
    if (idx >= REG_FIFO_STATUS_4) begin
      return REG_INVALID;
    end
    return reg_idx_e'(idx + 8'd1);
  endfunction

  assign cmd_bad = cmd_i.error
                || (cmd_i.code < 8'(`REC_CMD_FIRST))
                || (cmd_i.code > 8'(`REC_CMD_LAST))
                || (!recovery_mode_enabled_i && (cmd_i.code > 8'(`REC_CMD_MODE_LAST)));

  // Payload words, rounded up
  assign word_cnt = `REC_LEN_W'(cmd_i.len[`REC_LEN_W-1:2]) + `REC_LEN_W'(|cmd_i.len[1:0]);
  assign byte_hs  = res_dvalid_o & res_dready_i;

  always_comb begin
    start_idx = REG_INVALID;
    start_len = `REC_LEN_W'(`REC_LEN_DEFAULT);
    case (cmd_i.code)
      CMD_DEVICE_STATUS: begin
        start_idx = REG_DEVICE_STATUS;
        start_len = `REC_LEN_W'(`REC_LEN_DEVICE_STATUS);
      end
      CMD_DEVICE_RESET: begin
        start_idx = REG_DEVICE_RESET;
        start_len = `REC_LEN_W'(`REC_LEN_DEVICE_RESET);
      end
      CMD_RECOVERY_CTRL: begin
        start_idx = REG_RECOVERY_CTRL;
        start_len = `REC_LEN_W'(`REC_LEN_RECOVERY_CTRL);
      end
      CMD_INDIRECT_FIFO_CTRL: begin
        start_idx = REG_FIFO_CTRL_0;
        start_len = `REC_LEN_W'(`REC_LEN_FIFO_CTRL);
      end
      CMD_INDIRECT_FIFO_STATUS: begin
        start_idx = REG_FIFO_STATUS_0;
        start_len = `REC_LEN_W'(`REC_LEN_FIFO_STATUS);
      end
      default: ;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (cmd_valid_i) begin
          if (cmd_bad) begin
            state_d = ST_ERROR;
          end else if (cmd_i.is_rd) begin
            state_d = ST_READ;
          end else if (cmd_i.code == CMD_INDIRECT_FIFO_DATA) begin
            state_d = ST_FIFO_WRITE;
          end else begin
            state_d = ST_WRITE;
          end
        end
      end
      ST_WRITE, ST_FIFO_WRITE: begin
        // Zero-length writes finish without a request
        if ((dcnt_q == '0) || (tti_rx_rack_i && (dcnt_q == `REC_LEN_W'(1)))) begin
          state_d = ST_DONE;
        end
      end
      ST_READ: begin
        if (res_ready_i) begin
          state_d = ST_READ_LEN;
        end
      end
      ST_READ_LEN: state_d = ST_READ_DATA;
      ST_READ_DATA: begin
        if (host_abort_i) begin
          state_d = ST_ERROR;
        end else if (byte_hs && (dcnt_q == `REC_LEN_W'(1))) begin
          state_d = ST_DONE;
        end
      end
      ST_ERROR: state_d = ST_DONE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= ST_IDLE;
      dcnt_q        <= '0;
      bcnt_q        <= '0;
      reg_idx_q     <= REG_INVALID;
      res_len_q     <= '0;
      err_q         <= 1'b0;
      tti_rx_rreq_o <= 1'b0;
      res_valid_o   <= 1'b0;
    end else begin
      state_q       <= state_d;
      tti_rx_rreq_o <= 1'b0;
      res_valid_o   <= (state_q == ST_READ) & res_ready_i;
      case (state_q)
        ST_IDLE: begin
          if (cmd_valid_i) begin
            dcnt_q        <= word_cnt;
            bcnt_q        <= '0;
            reg_idx_q     <= start_idx;
            res_len_q     <= start_len;
            err_q         <= cmd_i.error;
            tti_rx_rreq_o <= !cmd_bad && !cmd_i.is_rd && (cmd_i.len != '0);
          end
        end
        ST_WRITE, ST_FIFO_WRITE: begin
          if (tti_rx_rack_i) begin
            dcnt_q        <= dcnt_q - 1'b1;
            reg_idx_q     <= step_idx(reg_idx_q);
            tti_rx_rreq_o <= (dcnt_q != `REC_LEN_W'(1));
          end
        end
        ST_READ_LEN: dcnt_q <= res_len_q;
        ST_READ_DATA: begin
          if (byte_hs) begin
            dcnt_q <= dcnt_q - 1'b1;
            bcnt_q <= bcnt_q + 1'b1;
            if (bcnt_q == 2'd3) begin
              reg_idx_q <= step_idx(reg_idx_q);
            end
          end
        end
        default: ;
      endcase
    end
  end

  assign reg_idx_o      = reg_idx_q;
  assign reg_we_o       = (state_q == ST_WRITE) & tti_rx_rack_i;
  assign fifo_push_o    = (state_q == ST_FIFO_WRITE) & tti_rx_rack_i;
  assign byte_sel_o     = bcnt_q;
  assign res_len_o      = res_len_q;
  assign res_dvalid_o   = (state_q == ST_READ_DATA);
  assign res_dlast_o    = res_dvalid_o & (dcnt_q == `REC_LEN_W'(1));
  assign cmd_done_o     = (state_q == ST_DONE);
  assign rx_queue_clr_o = (state_q == ST_ERROR);
  assign done_err_o     = '{done: cmd_done_o, err: err_q};

endmodule

`default_nettype wire

// ==== hw/rec_reg_pkg.sv ====
// Recovery register layouts
`default_nettype none

`include "rec_defines.svh"

package rec_reg_pkg;

  typedef struct packed {
    logic [7:0] rsvd;
    logic [7:0] if_ctrl;
    logic [7:0] forced_recovery;
    logic [7:0] reset_ctrl;
  } device_reset_t;

  typedef struct packed {
    logic [7:0] rsvd;
    logic [7:0] activate_rec_img;
    logic [7:0] rec_img_sel;
    logic [7:0] cms;
  } recovery_ctrl_t;

  // First word of INDIRECT_FIFO_CTRL
  typedef struct packed {
    logic [15:0] rsvd;
    logic [7:0]  reset;
    logic [7:0]  cms;
  } fifo_ctrl_t;

  // One TTI payload word, seen as the register it lands in
  typedef union packed {
    device_reset_t   dev_reset;
    recovery_ctrl_t  rec_ctrl;
    fifo_ctrl_t      fifo_ctrl;
    logic [3:0][7:0] bytes;
  } payload_word_u;

  typedef struct packed {
    logic [$clog2(`REC_FIFO_DEPTH)-1:0] write_index;
    logic [$clog2(`REC_FIFO_DEPTH)-1:0] read_index;
    logic                               full;
    logic                               empty;
  } fifo_status_t;

endpackage

`default_nettype wire

// ==== hw/rec_cmd_pkg.sv ====
// Recovery command types
`default_nettype none

`include "rec_defines.svh"

package rec_cmd_pkg;

  typedef enum logic [7:0] {
    CMD_PROT_CAP             = 8'd34,
    CMD_DEVICE_ID            = 8'd35,
    CMD_DEVICE_STATUS        = 8'd36,
    CMD_DEVICE_RESET         = 8'd37,
    CMD_RECOVERY_CTRL        = 8'd38,
    CMD_RECOVERY_STATUS      = 8'd39,
    CMD_HW_STATUS            = 8'd40,
    CMD_INDIRECT_CTRL        = 8'd41,
    CMD_INDIRECT_STATUS      = 8'd42,
    CMD_INDIRECT_DATA        = 8'd43,
    CMD_VENDOR               = 8'd44,
    CMD_INDIRECT_FIFO_CTRL   = 8'd45,
    CMD_INDIRECT_FIFO_STATUS = 8'd46,
    CMD_INDIRECT_FIFO_DATA   = 8'd47
  } command_e;

  typedef enum logic [7:0] {
    PROT_OK  = 8'h0,
    PROT_CRC = 8'h4
  } prot_err_e;

  // Word index into the recovery register space
  typedef enum logic [7:0] {
    REG_DEVICE_STATUS = 8'd0,
    REG_DEVICE_RESET  = 8'd1,
    REG_RECOVERY_CTRL = 8'd2,
    REG_FIFO_CTRL_0   = 8'd3,
    REG_FIFO_CTRL_1   = 8'd4,
    REG_FIFO_STATUS_0 = 8'd5,
    REG_FIFO_STATUS_1 = 8'd6,
    REG_FIFO_STATUS_2 = 8'd7,
    REG_FIFO_STATUS_3 = 8'd8,
    REG_FIFO_STATUS_4 = 8'd9,
    REG_INVALID       = 8'hFF
  } reg_idx_e;

  typedef struct packed {
    command_e              code;
    logic                  is_rd;
    logic [`REC_LEN_W-1:0] len;
    logic                  error;
  } rec_cmd_t;

  // End of command, with the error flag of that command
  typedef struct packed {
    logic done;
    logic err;
  } done_err_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_FIFO_WRITE,
    ST_READ,
    ST_READ_LEN,
    ST_READ_DATA,
    ST_ERROR,
    ST_DONE
  } state_e;

endpackage

`default_nettype wire

// ==== hw/rec_defines.svh ====
// Recovery executor parameters
`ifndef REC_DEFINES_SVH
`define REC_DEFINES_SVH

// Data path widths
`define REC_WORD_W 32
`define REC_LEN_W 16

// Indirect FIFO entries
`define REC_FIFO_DEPTH 64

// Legal command window
`define REC_CMD_FIRST 34
`define REC_CMD_LAST 47
// Highest code reachable outside recovery mode
`define REC_CMD_MODE_LAST 39

// Response lengths in bytes
`define REC_LEN_DEVICE_STATUS 4
`define REC_LEN_DEVICE_RESET 3
`define REC_LEN_RECOVERY_CTRL 3
`define REC_LEN_FIFO_CTRL 6
`define REC_LEN_FIFO_STATUS 20
`define REC_LEN_DEFAULT 4

`define REC_IMAGE_ACTIVATE 8'h0F

`endif
